// File: project.f
design/hc_read_pkg.sv
design/hc_issue_throttle.sv
design/hc_read_arbiter.sv
design/hc_read_requestor.sv
design/hc_csr_wb.sv
design/hc_read_subsys.sv
verification/hc_read_assert.sv
verification/hc_read_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the read path testbench with Verilator and runs it.
# The run passes only if the pass message shows up in the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module hc_read_tb --Mdir "$BUILD_DIR" -o hc_read_sim \
    -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/hc_read_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verification/read_tests.txt
// rd_base rd_count wr_base wr_count st_base st_count af_random en_delay total
// af_random 1 drives almost-full at random, en_delay is idle cycles before enable
00000100 0008 00000000 0000 00000000 0000 0 03 08
00001000 0006 00002000 0004 00003000 0003 0 02 0d
00004000 000e 00005000 000a 00006000 0005 1 04 1d
00000000 0000 fffffff0 0014 00000000 0000 0 20 14
00000000 0000 00000000 0000 00007000 000c 1 01 0c

// File: verification/hc_read_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the host-channel read request path
// Runs each line of the test file: sets up jobs over Wishbone, drives
// almost-full and checks every request that appears on the channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_read_tb
    import hc_read_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Words per test line and number of lines in the test file
    localparam int TEST_WORDS = 9;
    localparam int NUM_TESTS  = 5;

    logic                clk;
    logic                reset_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic                tx0_almostfull;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;
    hc_c0_tx_t           tx0;

    logic [31:0] test_mem [0:TEST_WORDS*NUM_TESTS-1];
    // Job of the running test per source indexed by the tag value
    logic [31:0] job_base [0:3];
    int          job_count [0:3];
    int          seen [0:3];
    int          seen_total;
    int          total;
    logic        af_random;
    logic        en_set;
    // Almost-full as the DUT saw it during the previous cycle
    logic        af_prev;
    int          af_issues;
    hc_src_e     last_tag;
    int          cycle_count;
    int          cycle_limit;
    integer      seed;

    hc_read_subsys uut (
        .clk(clk), .reset_n(reset_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .tx0_almostfull(tx0_almostfull), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .tx0(tx0)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic error_stop(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            error_stop($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                 name, actual, expected));
        end
    endtask

    // Classic handshake where ack is sampled in the middle of the cycle
    task automatic finish_cycle(output logic [WB_DAT_W-1:0] data);
        @(negedge clk);
        while (!wb_ack)
        begin
            @(negedge clk);
        end
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
        logic [WB_DAT_W-1:0] unused;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        finish_cycle(unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        finish_cycle(data);
    endtask

    // Checks one channel request against the job of its source
    task automatic compare_request();
        int          src;
        hc_src_e     exp_tag;
        logic [31:0] exp_addr;
        src = int'(tx0.hdr.tag);
        if (!en_set)
        begin
            error_stop("A read request appeared while the enable bit was clear");
        end
        if ((src == 0) || (seen[src] >= job_count[src]))
        begin
            error_stop("A read request appeared beyond the line count of its source");
        end
        // Reader and writer take turns while both still have lines
        if (!af_random && (seen[1] < job_count[1]) && (seen[2] < job_count[2]))
        begin
            exp_tag = (last_tag == SRC_READER) ? SRC_WRITER : SRC_READER;
            check_value("tx0.hdr.tag", tx0.hdr.tag, exp_tag);
        end
        if (src == 3)
        begin
            check_value("reader lines before status", seen[1], job_count[1]);
            check_value("writer lines before status", seen[2], job_count[2]);
        end
        exp_addr = job_base[src] + 32'(seen[src]);
        check_value("tx0.hdr.req_type", tx0.hdr.req_type, REQ_RDLINE);
        check_value("tx0.hdr.line_addr", tx0.hdr.line_addr, exp_addr);
        check_value("tx0.hdr.seq", tx0.hdr.seq, seen[src]);
        seen[src]  = seen[src] + 1;
        seen_total = seen_total + 1;
        last_tag   = tx0.hdr.tag;
    endtask

    // The channel monitor samples tx0 at the falling edge where it is stable
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (tx0.rd_valid)
            begin
                compare_request();
            end
            else if (!af_random && (seen_total > 0) && (seen_total < total))
            begin
                error_stop("The request burst stopped while almost-full was low");
            end
            // This request was granted in the cycle that af_prev covers
            if (!af_prev)
            begin
                af_issues = 0;
            end
            else if (tx0.rd_valid)
            begin
                af_issues = af_issues + 1;
            end
            if (af_issues > ISSUE_SLACK)
            begin
                error_stop("Too many requests were issued while almost-full was high");
            end
            af_prev = tx0_almostfull;
        end
    end

    always @(posedge clk)
    begin
        if (af_random)
        begin
            tx0_almostfull <= 1'($random(seed) & 1);
        end
        else
        begin
            tx0_almostfull <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            error_stop("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic run_test(input int t);
        int                  w;
        logic [WB_DAT_W-1:0] data;
        logic [2:0]          exp_busy;
        w = t * TEST_WORDS;
        wb_write(CSR_CTRL, 32'd0);
        en_set = 1'b0;
        for (int s = 1; s <= 3; s++)
        begin
            job_base[s]  = test_mem[w + 2*s - 2];
            job_count[s] = int'(test_mem[w + 2*s - 1]);
            seen[s]      = 0;
        end
        af_random  = test_mem[w + 6][0];
        total      = int'(test_mem[w + 8]);
        seen_total = 0;
        last_tag   = SRC_NONE;
        // Register pairs follow source order with base at 2s-1 and count at 2s
        for (int s = 1; s <= 3; s++)
        begin
            wb_write(WB_ADR_W'(2*s - 1), job_base[s]);
        end
        for (int s = 1; s <= 3; s++)
        begin
            if (job_count[s] != 0)
            begin
                wb_write(WB_ADR_W'(2*s), job_count[s]);
            end
        end
        // Jobs are now pending so a second count write must be ignored
        for (int s = 1; s <= 3; s++)
        begin
            if (job_count[s] != 0)
            begin
                wb_write(WB_ADR_W'(2*s), job_count[s] + 3);
            end
            wb_read(WB_ADR_W'(2*s), data);
            check_value("pending count register", data, job_count[s]);
        end
        exp_busy = {job_count[3] != 0, job_count[2] != 0, job_count[1] != 0};
        wb_read(CSR_BUSY, data);
        check_value("CSR_BUSY while pending", data, exp_busy);
        repeat (test_mem[w + 7]) @(posedge clk);
        en_set = 1'b1;
        wb_write(CSR_CTRL, 32'd1);
        // All jobs are done once every busy bit has fallen
        wb_read(CSR_BUSY, data);
        while (data != '0)
        begin
            wb_read(CSR_BUSY, data);
        end
        check_value("request total", seen_total, total);
        for (int s = 1; s <= 3; s++)
        begin
            check_value($sformatf("requests of source %0d", s), seen[s], job_count[s]);
        end
        for (int s = 1; s <= 3; s++)
        begin
            wb_read(WB_ADR_W'(2*s), data);
            check_value("final count register", data, 0);
        end
        // Quiet cycles in which the monitor would catch a stray request
        repeat (5) @(posedge clk);
    endtask

    initial
    begin
        seed           = 32'h8199_be59;
        reset_n        = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        tx0_almostfull = 1'b0;
        af_random      = 1'b0;
        en_set         = 1'b0;
        af_prev        = 1'b0;
        af_issues      = 0;
        seen_total     = 0;
        total          = 0;
        last_tag       = SRC_NONE;
        cycle_count    = 0;
        $readmemh("verification/read_tests.txt", test_mem);
        cycle_limit = 0;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            cycle_limit = cycle_limit + 20 * int'(test_mem[t*TEST_WORDS + 8]) + 200;
        end
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: verification/hc_read_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on arbitration and issue throttling
// Bound into the arbiter, whose can_issue input is the throttle output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_read_assert
    import hc_read_pkg::*;
(
    input logic           clk,
    input logic           reset_n,
    input logic           can_issue,
    input hc_read_grant_t grant,
    input hc_c0_tx_t      tx0
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] grant_bits;

    assign grant_bits = {grant.reader_grant, grant.writer_grant, grant.status_grant};

    // The channel takes one source per cycle
    one_grant: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(grant_bits))
        else $error("More than one read grant in one cycle");

    // Without credit or enable the throttle must hold every source back
    no_grant_when_blocked: assert property (@(posedge clk) disable iff (!reset_n)
        !can_issue |-> (grant_bits == 3'b000))
        else $error("Read grant given while can_issue was low");

    // An idle channel slot never looks like a line read
    idle_slot_is_none: assert property (@(posedge clk) disable iff (!reset_n)
        !tx0.rd_valid |-> (tx0.hdr.req_type == REQ_NONE))
        else $error("Request type is not REQ_NONE while rd_valid is low");

endmodule

bind hc_read_arbiter hc_read_assert u_arb_assert (
    .clk(clk), .reset_n(reset_n), .can_issue(can_issue), .grant(grant), .tx0(tx0)
);

// File: design/hc_read_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the host-channel read request path
// Wishbone registers in, tagged line-read requests out on tx0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_read_subsys
    import hc_read_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    input  logic                tx0_almostfull,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    output hc_c0_tx_t           tx0
);

    hc_job_t            rd_job;
    hc_job_t            wr_job;
    hc_job_t            st_job;
    logic               afu_en;
    // Bit 0 reader, bit 1 writer, bit 2 status
    logic [2:0]         busy;
    logic [COUNT_W-1:0] rd_remaining;
    logic [COUNT_W-1:0] wr_remaining;
    logic [COUNT_W-1:0] st_remaining;
    hc_read_req_t       reader_req;
    hc_read_req_t       writer_req;
    hc_read_req_t       status_req;
    hc_read_grant_t     grant;
    logic               can_issue;

    hc_csr_wb u_csr (
        .clk(clk), .reset_n(reset_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .busy(busy),
        .rd_remaining(rd_remaining), .wr_remaining(wr_remaining),
        .st_remaining(st_remaining), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .afu_en(afu_en), .rd_job(rd_job), .wr_job(wr_job), .st_job(st_job)
    );

    // Same engine three times, told apart by the source tag
    hc_read_requestor u_reader (
        .clk(clk), .reset_n(reset_n), .job(rd_job), .src(SRC_READER),
        .grant(grant.reader_grant), .req(reader_req), .busy(busy[0]),
        .remaining(rd_remaining)
    );

    hc_read_requestor u_writer (
        .clk(clk), .reset_n(reset_n), .job(wr_job), .src(SRC_WRITER),
        .grant(grant.writer_grant), .req(writer_req), .busy(busy[1]),
        .remaining(wr_remaining)
    );

    hc_read_requestor u_status (
        .clk(clk), .reset_n(reset_n), .job(st_job), .src(SRC_STATUS),
        .grant(grant.status_grant), .req(status_req), .busy(busy[2]),
        .remaining(st_remaining)
    );

    hc_read_arbiter u_arbiter (
        .clk(clk), .reset_n(reset_n), .can_issue(can_issue),
        .reader(reader_req), .writer(writer_req), .status(status_req),
        .grant(grant), .tx0(tx0)
    );

    // Any granted source counts as one issue against the credits
    hc_issue_throttle u_throttle (
        .clk(clk), .reset_n(reset_n), .almostfull(tx0_almostfull),
        .afu_en(afu_en),
        .issue(grant.reader_grant | grant.writer_grant | grant.status_grant),
        .can_issue(can_issue)
    );

endmodule

// File: design/hc_csr_wb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic register block for the read request path
// Holds the enable bit and job bases, starts idle requestors on a
// nonzero count write and reports busy bits and remaining counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_csr_wb
    import hc_read_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    // Busy bits in the order reader, writer, status
    input  logic [2:0]          busy,
    input  logic [COUNT_W-1:0]  rd_remaining,
    input  logic [COUNT_W-1:0]  wr_remaining,
    input  logic [COUNT_W-1:0]  st_remaining,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    output logic                afu_en,
    output hc_job_t             rd_job,
    output hc_job_t             wr_job,
    output hc_job_t             st_job
);

    hc_csr_addr_e           csr_addr;
    logic                   wb_req;
    logic                   count_wr;
    logic [WB_DAT_W-1:0]    read_data;
    logic [2:0]             start_q;
    logic [COUNT_W-1:0]     count_q;
    logic [LINE_ADDR_W-1:0] rd_base;
    logic [LINE_ADDR_W-1:0] wr_base;
    logic [LINE_ADDR_W-1:0] st_base;

    assign csr_addr = hc_csr_addr_e'(wb_adr);
    // New cycle seen, the ack term keeps one access from acking twice
    assign wb_req   = wb_cyc && wb_stb && !wb_ack;
    // A zero count never starts a job
    assign count_wr = wb_req && wb_we && (wb_dat_w[COUNT_W-1:0] != '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wb_ack  <= 1'b0;
            afu_en  <= 1'b0;
            start_q <= '0;
        end
        else
        begin
            wb_ack  <= wb_req;
            start_q <= '0;
            if (wb_req && wb_we && (csr_addr == CSR_CTRL))
            begin
                afu_en <= wb_dat_w[0];
            end
            // Start pulses go out with ack, and only to idle requestors
            if (count_wr)
            begin
                case (csr_addr)
                    CSR_RD_COUNT: start_q[0] <= !busy[0];
                    CSR_WR_COUNT: start_q[1] <= !busy[1];
                    CSR_ST_COUNT: start_q[2] <= !busy[2];
                    default: start_q <= '0;
                endcase
            end
        end
    end

    // Bases, job count and read data
    always_ff @(posedge clk)
    begin
        if (wb_req && wb_we)
        begin
            case (csr_addr)
                CSR_RD_BASE: rd_base <= wb_dat_w[LINE_ADDR_W-1:0];
                CSR_WR_BASE: wr_base <= wb_dat_w[LINE_ADDR_W-1:0];
                CSR_ST_BASE: st_base <= wb_dat_w[LINE_ADDR_W-1:0];
                default: count_q <= wb_dat_w[COUNT_W-1:0];
            endcase
        end
        if (wb_req && !wb_we)
        begin
            wb_dat_r <= read_data;
        end
    end

    // Count registers read back what the running job still has to issue
    always_comb
    begin
        case (csr_addr)
            CSR_CTRL:     read_data = WB_DAT_W'(afu_en);
            CSR_RD_BASE:  read_data = WB_DAT_W'(rd_base);
            CSR_RD_COUNT: read_data = WB_DAT_W'(rd_remaining);
            CSR_WR_BASE:  read_data = WB_DAT_W'(wr_base);
            CSR_WR_COUNT: read_data = WB_DAT_W'(wr_remaining);
            CSR_ST_BASE:  read_data = WB_DAT_W'(st_base);
            CSR_ST_COUNT: read_data = WB_DAT_W'(st_remaining);
            CSR_BUSY:     read_data = WB_DAT_W'(busy);
            default:      read_data = '0;
        endcase
    end

    // Each job uses the base held when its count is written
    always_comb
    begin
        rd_job.start = start_q[0];
        rd_job.base  = rd_base;
        rd_job.count = count_q;
        wr_job.start = start_q[1];
        wr_job.base  = wr_base;
        wr_job.count = count_q;
        st_job.start = start_q[2];
        st_job.base  = st_base;
        st_job.count = count_q;
    end

endmodule

// File: design/hc_read_requestor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line-read job engine, one instance per request source
// A start loads base and count, then one line is requested per grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_read_requestor
    import hc_read_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    // Job setup pulse from the register block
    input  hc_job_t            job,
    // Fixed source tag of this instance
    input  hc_src_e            src,
    // Grant bit of this source from the arbiter
    input  logic               grant,
    output hc_read_req_t       req,
    output logic               busy,
    // Lines of the current job not yet issued
    output logic [COUNT_W-1:0] remaining
);

    logic [LINE_ADDR_W-1:0] base;
    logic [COUNT_W-1:0]     line_seq;

    // Remaining count is the control state, busy follows from it
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining <= '0;
        end
        else if (job.start)
        begin
            remaining <= job.count;
        end
        else if (grant && busy)
        begin
            remaining <= remaining - 1'b1;
        end
    end

    // Address state of the job in flight
    always_ff @(posedge clk)
    begin
        if (job.start)
        begin
            base     <= job.base;
            line_seq <= '0;
        end
        else if (grant && busy)
        begin
            line_seq <= line_seq + 1'b1;
        end
    end

    assign busy = (remaining != '0);

    // Offer stays up with a stable header until the grant is seen
    always_comb
    begin
        req.request       = busy;
        req.hdr.req_type  = busy ? REQ_RDLINE : REQ_NONE;
        req.hdr.tag       = src;
        req.hdr.line_addr = base + LINE_ADDR_W'(line_seq);
        req.hdr.seq       = line_seq;
    end

endmodule

// File: design/hc_read_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read channel arbiter for the reader, writer and status requestors
// Reader and writer alternate, status only fills idle slots, and the
// winning header is registered onto the channel one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_read_arbiter
    import hc_read_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    // Credit and enable check from the throttle
    input  logic           can_issue,
    // Offers from the three requestors
    input  hc_read_req_t   reader,
    input  hc_read_req_t   writer,
    input  hc_read_req_t   status,
    output hc_read_grant_t grant,
    // Registered request toward the memory read channel
    output hc_c0_tx_t      tx0
);

    // Which of reader and writer wins when both are waiting
    typedef enum logic {
        FAVOR_READER,
        FAVOR_WRITER
    } favor_e;

    favor_e      favor;
    favor_e      favor_next;
    hc_req_hdr_t winner_hdr;
    logic        issue_valid;
    hc_c0_tx_t   tx0_next;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            favor <= FAVOR_READER;
        end
        else
        begin
            favor <= favor_next;
        end
    end

    // Writer gets the next turn only right after a reader grant
    assign favor_next = grant.reader_grant ? FAVOR_WRITER : FAVOR_READER;

    always_comb
    begin
        grant           = '0;
        grant.can_issue = can_issue;
        // Reader header is the default so the mux stays small
        winner_hdr      = reader.hdr;

        if (reader.request && ((favor == FAVOR_READER) || !writer.request))
        begin
            grant.reader_grant = can_issue;
        end
        else if (writer.request)
        begin
            winner_hdr         = writer.hdr;
            grant.writer_grant = can_issue;
        end
        else if (status.request)
        begin
            // Status traffic only uses slots the frame engines leave free
            winner_hdr         = status.hdr;
            grant.status_grant = can_issue;
        end
    end

    assign issue_valid = grant.reader_grant | grant.writer_grant | grant.status_grant;

    always_comb
    begin
        tx0_next          = '0;
        tx0_next.rd_valid = issue_valid;
        tx0_next.hdr      = winner_hdr;
        // An idle slot must never look like a line read
        if (!issue_valid)
        begin
            tx0_next.hdr.req_type = REQ_NONE;
        end
    end

    // A grant in one cycle becomes rd_valid in the next
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx0 <= '0;
        end
        else
        begin
            tx0 <= tx0_next;
        end
    end

endmodule

// File: design/hc_issue_throttle.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue credit counter for the read channel
// Gates the arbiter so only a few requests follow an almost-full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hc_issue_throttle
    import hc_read_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    // Back-pressure from the read channel
    input  logic almostfull,
    // Software enable bit from the register block
    input  logic afu_en,
    // High for any granted request in this cycle
    input  logic issue,
    output logic can_issue
);

    // Issues left before the channel must drop almost-full again
    logic [CREDIT_W-1:0] credit;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            credit <= CREDIT_W'(ISSUE_SLACK);
        end
        else if (!almostfull)
        begin
            // Channel has room, so the full slack is available again
            credit <= CREDIT_W'(ISSUE_SLACK);
        end
        else if (issue && (credit != '0))
        begin
            // Each issue under almost-full spends one credit
            credit <= credit - 1'b1;
        end
    end

    // Issue needs both a credit and software permission
    assign can_issue = (credit != '0) && afu_en;

endmodule

// File: design/hc_read_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, enums and packed structs for the host-channel read path
// Each design module pulls these in with a wildcard import in its header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hc_read_pkg;

    // Width of a cache-line address on the read channel
    localparam int LINE_ADDR_W = 32;
    // Width of a job line count and of the per-request sequence number
    localparam int COUNT_W = 16;
    // Wishbone word address and data widths of the register port
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;
    // Issues still allowed once almost-full has been seen high
    localparam int ISSUE_SLACK = 2;
    // Enough bits to hold a full set of issue credits
    localparam int CREDIT_W = $clog2(ISSUE_SLACK + 1);

    // Source tag carried by every read request
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_READER,
        SRC_WRITER,
        SRC_STATUS
    } hc_src_e;

    // Kind of channel request, REQ_NONE marks an idle slot
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_RDLINE
    } hc_req_type_e;

    // Word addresses of the register block
    typedef enum logic [WB_ADR_W-1:0] {
        CSR_CTRL     = 4'd0,
        CSR_RD_BASE  = 4'd1,
        CSR_RD_COUNT = 4'd2,
        CSR_WR_BASE  = 4'd3,
        CSR_WR_COUNT = 4'd4,
        CSR_ST_BASE  = 4'd5,
        CSR_ST_COUNT = 4'd6,
        CSR_BUSY     = 4'd7
    } hc_csr_addr_e;

    // Request header as it travels from requestor to channel
    typedef struct packed {
        hc_req_type_e           req_type;
        hc_src_e                tag;
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [COUNT_W-1:0]     seq;
    } hc_req_hdr_t;

    // A requestor's offer to the arbiter
    typedef struct packed {
        logic        request;
        hc_req_hdr_t hdr;
    } hc_read_req_t;

    // One-cycle job start from the register block to a requestor
    typedef struct packed {
        logic                   start;
        logic [LINE_ADDR_W-1:0] base;
        logic [COUNT_W-1:0]     count;
    } hc_job_t;

    // Arbiter decision, at most one grant bit is set at a time
    typedef struct packed {
        logic can_issue;
        logic reader_grant;
        logic writer_grant;
        logic status_grant;
    } hc_read_grant_t;

    // Registered request on the memory read channel
    typedef struct packed {
        logic        rd_valid;
        hc_req_hdr_t hdr;
    } hc_c0_tx_t;

endpackage
